// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

	localparam int ADDR_W = 16;
	localparam int WORD_W = 16;
	// opcode in the low byte, operand bytes above it
	localparam int INST_W = 24;

	typedef enum logic [7:0] {
		NOP         = 8'h00,
		LD_XL_IMMD  = 8'h10,
		ADD_XL_IMMD = 8'h11,
		SUB_XL_IMMD = 8'h12,
		AND_XL_IMMD = 8'h13,
		OR_XL_IMMD  = 8'h14,
		XOR_XL_IMMD = 8'h15,
		CP_XL_IMMD  = 8'h16,
		LD_XL_DIR   = 8'h20,
		ADD_XL_DIR  = 8'h21,
		LD_DIR_XL   = 8'h22,
		LDW_Y_IMMD  = 8'h30,
		ADDW_Y_IMMD = 8'h31,
		LDW_X_Y     = 8'h32,
		LDW_DIR_Y   = 8'h33,
		JR_D        = 8'h40,
		JRZ_D       = 8'h41,
		JRNZ_D      = 8'h42,
		JRC_D       = 8'h43,
		JRNC_D      = 8'h44,
		TRAP        = 8'hff
	} opcode_t;

	typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, PASS, ADDW, PASSW} alu_op_t;

	typedef enum logic {REG_X, REG_Y} reg_sel_t;

	typedef struct packed {
		logic c;
		logic n;
		logic z;
	} flags_t;

	typedef struct packed {
		alu_op_t op;
		logic [WORD_W-1:0] a;
		logic [WORD_W-1:0] b;
	} alu_req_t;

	typedef struct packed {
		logic [WORD_W-1:0] result;
		flags_t flags;
	} alu_res_t;

	// en[0] is the low byte
	typedef struct packed {
		logic [1:0] en;
		reg_sel_t sel;
		logic [WORD_W-1:0] data;
	} reg_wr_t;

	function automatic logic [1:0] instr_len(input logic [7:0] op);
		case (op)
			LD_XL_IMMD, ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD,
			CP_XL_IMMD, JR_D, JRZ_D, JRNZ_D, JRC_D, JRNC_D:
				return 2'd2;
			LD_XL_DIR, ADD_XL_DIR, LD_DIR_XL, LDW_Y_IMMD, ADDW_Y_IMMD, LDW_DIR_Y:
				return 2'd3;
			default:
				return 2'd1;
		endcase
	endfunction

endpackage

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input alu_req_t req,
	output alu_res_t res
);
	logic [7:0] a8;
	logic [7:0] b8;
	logic [8:0] sum8;
	logic [8:0] diff8;
	logic [WORD_W:0] sum16;
	logic [WORD_W-1:0] result;
	logic carry;
	logic wide;

	assign a8 = req.a[7:0];
	assign b8 = req.b[7:0];
	assign sum8 = {1'b0, a8} + {1'b0, b8};
	// bit 8 is the borrow, set when a < b
	assign diff8 = {1'b0, a8} - {1'b0, b8};
	assign sum16 = {1'b0, req.a} + {1'b0, req.b};
	assign wide = (req.op == ADDW) || (req.op == PASSW);

	always_comb
	begin
		carry = 1'b0;
		case (req.op)
			ADD:
			begin
				result = {8'h00, sum8[7:0]};
				carry = sum8[8];
			end
			SUB:
			begin
				result = {8'h00, diff8[7:0]};
				carry = diff8[8];
			end
			AND:
				result = {8'h00, a8 & b8};
			OR:
				result = {8'h00, a8 | b8};
			XOR:
				result = {8'h00, a8 ^ b8};
			ADDW:
			begin
				result = sum16[WORD_W-1:0];
				carry = sum16[WORD_W];
			end
			PASSW:
				result = req.a;
			default:
				result = {8'h00, a8};
		endcase
	end

	// n and z from the low byte unless word op
	assign res = '{
		result: result,
		flags: '{
			c: carry,
			n: wide ? result[WORD_W-1] : result[7],
			z: wide ? (result == '0) : (result[7:0] == 8'h00)
		}
	};

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps

module regfile import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input reg_wr_t wr,
	output logic [WORD_W-1:0] x,
	output logic [WORD_W-1:0] y
);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			x <= '0;
			y <= '0;
		end
		else
		begin
			// each byte lane written on its own
			if (wr.sel == REG_X && wr.en[0])
				x[7:0] <= wr.data[7:0];
			if (wr.sel == REG_X && wr.en[1])
				x[15:8] <= wr.data[15:8];
			if (wr.sel == REG_Y && wr.en[0])
				y[7:0] <= wr.data[7:0];
			if (wr.sel == REG_Y && wr.en[1])
				y[15:8] <= wr.data[15:8];
		end
	end

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; #(
	parameter logic [ADDR_W-1:0] RESET_PC = 16'h4000
) (
	input logic clk,
	input logic reset,
	input flags_t next_flags,
	output logic [ADDR_W-1:0] iread_addr,
	input logic [INST_W-1:0] iread_data,
	output logic [ADDR_W-1:0] dread_addr,
	output logic [INST_W-1:0] inst,
	output logic [ADDR_W-1:0] inst_pc
);
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] next_pc;
	logic [ADDR_W-1:0] branch_pc;
	logic [7:0] fetch_op;
	logic [7:0] disp;
	logic taken;

	assign fetch_op = iread_data[7:0];
	assign disp = iread_data[15:8];
	assign iread_addr = pc;

	// direct operand goes straight to the data memory, data comes back next cycle
	assign dread_addr = iread_data[23:8];

	// flags as the instruction now in execute leaves them
	always_comb
	begin
		case (fetch_op)
			JR_D:
				taken = 1'b1;
			JRZ_D:
				taken = next_flags.z;
			JRNZ_D:
				taken = !next_flags.z;
			JRC_D:
				taken = next_flags.c;
			JRNC_D:
				taken = !next_flags.c;
			default:
				taken = 1'b0;
		endcase
	end

	// relative to the byte after the jump
	assign branch_pc = pc + ADDR_W'(2) + {{(ADDR_W-8){disp[7]}}, disp};
	assign next_pc = taken ? branch_pc : pc + ADDR_W'(instr_len(fetch_op));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= RESET_PC;
			inst <= {{(INST_W-8){1'b0}}, NOP};
		end
		else
		begin
			pc <= next_pc;
			inst <= iread_data;
		end
	end

	always_ff @(posedge clk)
	begin
		inst_pc <= pc;
	end

endmodule

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [INST_W-1:0] inst,
	input logic [WORD_W-1:0] x,
	input logic [WORD_W-1:0] y,
	input logic [WORD_W-1:0] dread_data,
	input alu_res_t alu_res,
	output alu_req_t alu_req,
	output reg_wr_t reg_wr,
	output flags_t next_flags,
	output logic [ADDR_W-1:0] dwrite_addr,
	output logic [WORD_W-1:0] dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);
	opcode_t opcode;
	logic [WORD_W-1:0] imm8;
	logic [WORD_W-1:0] imm16;
	flags_t flags;
	logic upd_c;
	logic upd_nz;

	assign opcode = opcode_t'(inst[7:0]);
	assign imm8 = {8'h00, inst[15:8]};
	assign imm16 = inst[23:8];

	always_comb
	begin
		alu_req.op = PASS;
		alu_req.a = x;
		alu_req.b = imm8;
		reg_wr.en = 2'b00;
		reg_wr.sel = REG_X;
		reg_wr.data = alu_res.result;
		upd_c = 1'b0;
		upd_nz = 1'b0;
		dwrite_en = 2'b00;
		trap = 1'b0;
		case (opcode)
			LD_XL_IMMD:
			begin
				alu_req.a = imm8;
				reg_wr.en = 2'b01;
			end
			ADD_XL_IMMD, SUB_XL_IMMD, ADD_XL_DIR:
			begin
				alu_req.op = (opcode == SUB_XL_IMMD) ? SUB : ADD;
				alu_req.b = (opcode == ADD_XL_DIR) ? dread_data : imm8;
				reg_wr.en = 2'b01;
				upd_c = 1'b1;
				upd_nz = 1'b1;
			end
			AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD:
			begin
				alu_req.op = (opcode == AND_XL_IMMD) ? AND : (opcode == OR_XL_IMMD) ? OR : XOR;
				reg_wr.en = 2'b01;
				upd_nz = 1'b1;
			end
			// subtract for the flags only
			CP_XL_IMMD:
			begin
				alu_req.op = SUB;
				upd_c = 1'b1;
				upd_nz = 1'b1;
			end
			LD_XL_DIR:
			begin
				alu_req.a = dread_data;
				reg_wr.en = 2'b01;
			end
			LD_DIR_XL:
				dwrite_en = 2'b01;
			LDW_Y_IMMD, ADDW_Y_IMMD, LDW_X_Y:
			begin
				alu_req.op = (opcode == ADDW_Y_IMMD) ? ADDW : PASSW;
				alu_req.a = (opcode == LDW_Y_IMMD) ? imm16 : y;
				alu_req.b = imm16;
				reg_wr.en = 2'b11;
				reg_wr.sel = (opcode == LDW_X_Y) ? REG_X : REG_Y;
				upd_c = (opcode == ADDW_Y_IMMD);
				upd_nz = (opcode == ADDW_Y_IMMD);
			end
			LDW_DIR_Y:
			begin
				alu_req.op = PASSW;
				alu_req.a = y;
				dwrite_en = 2'b11;
			end
			TRAP:
				trap = 1'b1;
			default:
				;
		endcase
	end

	// store data passes through the alu
	assign dwrite_addr = imm16;
	assign dwrite_data = alu_res.result;

	assign next_flags = '{
		c: upd_c ? alu_res.flags.c : flags.c,
		n: upd_nz ? alu_res.flags.n : flags.n,
		z: upd_nz ? alu_res.flags.z : flags.z
	};

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

endmodule

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
	parameter logic [ADDR_W-1:0] RESET_PC = 16'h4000
) (
	input logic clk,
	input logic reset,
	output logic [ADDR_W-1:0] iread_addr,
	input logic [INST_W-1:0] iread_data,
	output logic [ADDR_W-1:0] dread_addr,
	input logic [WORD_W-1:0] dread_data,
	output logic [ADDR_W-1:0] dwrite_addr,
	output logic [WORD_W-1:0] dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);
	logic [INST_W-1:0] inst;
	flags_t next_flags;
	alu_req_t alu_req;
	alu_res_t alu_res;
	reg_wr_t reg_wr;
	logic [WORD_W-1:0] x;
	logic [WORD_W-1:0] y;

	fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
		.clk(clk),
		.reset(reset),
		.next_flags(next_flags),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.dread_addr(dread_addr),
		.inst(inst),
		.inst_pc()
	);

	exec_unit u_exec (
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.x(x),
		.y(y),
		.dread_data(dread_data),
		.alu_res(alu_res),
		.alu_req(alu_req),
		.reg_wr(reg_wr),
		.next_flags(next_flags),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	alu u_alu (.req(alu_req), .res(alu_res));

	regfile u_regfile (.clk(clk), .reset(reset), .wr(reg_wr), .x(x), .y(y));

endmodule

// ==== verif/cpu_sva.sv ====
`timescale 1ns/1ps

module cpu_sva import cpu_pkg::*; #(
	parameter logic [ADDR_W-1:0] RESET_PC = 16'h4000
) (
	input logic clk,
	input logic reset,
	input logic [ADDR_W-1:0] iread_addr,
	input logic [INST_W-1:0] iread_data,
	input logic [1:0] dwrite_en,
	input logic trap
);
	logic is_jump;
	logic [ADDR_W-1:0] seq_pc;

	assign is_jump = iread_data[7:0] inside {JR_D, JRZ_D, JRNZ_D, JRC_D, JRNC_D};
	assign seq_pc = iread_addr + ADDR_W'(instr_len(iread_data[7:0]));

	first_fetch: assert property (@(posedge clk) $fell(reset) |-> iread_addr == RESET_PC)
		else $error("first fetch after reset went to %h", $sampled(iread_addr));

	// straight-line code steps by the instruction length
	sequential_fetch: assert property (@(posedge clk) disable iff (reset)
		!is_jump |=> iread_addr == $past(seq_pc))
		else $error("fetch address %h does not follow the previous instruction",
			$sampled(iread_addr));

	quiet_reset: assert property (@(posedge clk) reset ##1 reset |-> dwrite_en == 2'b00 && !trap)
		else $error("store or trap seen while reset is held");

endmodule

// iread_addr is the fetch pc
bind cpu_top cpu_sva #(.RESET_PC(RESET_PC)) u_sva (
	.clk(clk),
	.reset(reset),
	.iread_addr(iread_addr),
	.iread_data(iread_data),
	.dwrite_en(dwrite_en),
	.trap(trap)
);

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();
	localparam int RESET_CYCLES = 5;
	localparam int NUM_TESTS = 6;
	localparam int TEST_CYCLES = 80;
	// reset and slack on top of the longest programs
	localparam int MAX_CYCLES = NUM_TESTS * TEST_CYCLES + 120;

	logic clk;
	logic reset;
	logic [15:0] iread_addr;
	logic [23:0] iread_data;
	logic [15:0] dread_addr;
	logic [15:0] dread_data;
	logic [15:0] dwrite_addr;
	logic [15:0] dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;

	logic [7:0] imem [0:1023];
	logic [15:0] dmem [0:255];
	logic [7:0] dread_idx;
	logic [15:0] exp_addr [0:31];
	logic [15:0] exp_data [0:31];
	logic [1:0] exp_en [0:31];
	int exp_count = 0;
	int exp_head = 0;
	int store_errors = 0;
	int missing_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;
	logic [15:0] wp;
	logic [31:0] lcg_state;
	string test_name;

	cpu_top #(.RESET_PC(16'h4000)) DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// three bytes, opcode first
	assign iread_data = {imem[10'(iread_addr + 16'd2)], imem[10'(iread_addr + 16'd1)],
		imem[iread_addr[9:0]]};
	assign dread_data = dmem[dread_idx];

	always @(posedge clk)
	begin
		dread_idx <= dread_addr[7:0];
		if (dwrite_en[0])
			dmem[dwrite_addr[7:0]][7:0] <= dwrite_data[7:0];
		if (dwrite_en[1])
			dmem[dwrite_addr[7:0]][15:8] <= dwrite_data[15:8];
		if (reset)
			exp_head <= 0;
		else if (dwrite_en != 2'b00)
			exp_head <= exp_head + 1;
		cycle_count <= cycle_count + 1;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic store_matches(input logic [15:0] addr, input logic [15:0] data,
		input logic [1:0] en, input int idx);
		logic [15:0] mask;
		mask = {{8{en[1]}}, {8{en[0]}}};
		return addr == exp_addr[idx] && en == exp_en[idx] && (data & mask) == (exp_data[idx] & mask);
	endfunction

	store_check: assert property (@(posedge clk) disable iff (reset)
		dwrite_en != 2'b00 && exp_head < exp_count
			|-> store_matches(dwrite_addr, dwrite_data, dwrite_en, exp_head))
	else
	begin
		store_errors++;
		$display("** Error: %s store %0d expected %h at %h, actual %h at %h", test_name,
			$sampled(exp_head), exp_data[$sampled(exp_head)], exp_addr[$sampled(exp_head)],
			$sampled(dwrite_data), $sampled(dwrite_addr));
	end

	extra_store_check: assert property (@(posedge clk) disable iff (reset)
		dwrite_en != 2'b00 |-> exp_head < exp_count)
	else
	begin
		other_errors++;
		$display("%s: store to %h when no store was expected", test_name, $sampled(dwrite_addr));
	end

	trap_check: assert property (@(posedge clk) disable iff (reset) trap |-> exp_head == exp_count)
	else
	begin
		missing_errors++;
		$display("%s: trap came with stores still missing", test_name);
	end

	trap_once_check: assert property (@(posedge clk) disable iff (reset) trap |=> !trap)
	else
	begin
		other_errors++;
		$display("%s: trap stayed high for more than one cycle", test_name);
	end

	task automatic put1(input opcode_t op);
		imem[wp[9:0]] = op;
		wp = wp + 16'd1;
	endtask

	task automatic put2(input opcode_t op, input logic [7:0] b);
		put1(op);
		imem[wp[9:0]] = b;
		wp = wp + 16'd1;
	endtask

	task automatic put3(input opcode_t op, input logic [15:0] w);
		put2(op, w[7:0]);
		imem[wp[9:0]] = w[15:8];
		wp = wp + 16'd1;
	endtask

	task automatic expect_store(input logic [15:0] addr, input logic [15:0] data,
		input logic [1:0] en);
		exp_addr[exp_count] = addr;
		exp_data[exp_count] = data;
		exp_en[exp_count] = en;
		exp_count++;
	endtask

	task automatic begin_test(input string name);
		reset = 1'b1;
		test_name = name;
		exp_count = 0;
		wp = 16'h4000;
		for (int i = 0; i < 1024; i++)
			imem[i] = 8'h00;
	endtask

	// ends the program with trap, releases reset and waits for the trap
	task automatic run_program();
		put1(TRAP);
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		do
			@(negedge clk);
		while (trap !== 1'b1);
		// the cycle after trap still runs out of reset
		repeat (2) @(posedge clk);
		#1;
	endtask

	function automatic logic [7:0] alu8_model(input opcode_t op, input logic [7:0] a,
		input logic [7:0] b);
		case (op)
			ADD_XL_IMMD: return a + b;
			SUB_XL_IMMD: return a - b;
			AND_XL_IMMD: return a & b;
			OR_XL_IMMD: return a | b;
			XOR_XL_IMMD: return a ^ b;
			default: return a;
		endcase
	endfunction

	initial
	begin
		wait (cycle_count >= MAX_CYCLES);
		$display("timeout: %s did not reach trap within %0d cycles", test_name, MAX_CYCLES);
		$display("errors: store %0d, missing %0d, other %0d", store_errors, missing_errors,
			other_errors);
		$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		logic [7:0] a;
		logic [7:0] b;
		logic [15:0] w1;
		logic [15:0] w2;
		logic taken;
		opcode_t op;
		lcg_state = 32'hebb76fe7;
		dread_idx = 8'h00;
		for (int i = 0; i < 256; i++)
			dmem[i] = 16'h0000;

		begin_test("alu8_immd");
		for (int i = 0; i < 12; i++)
		begin
			a = 8'(next_rand() >> 16);
			b = 8'(next_rand() >> 16);
			// add, sub, and, or, xor, cp in opcode order
			op = opcode_t'(8'h11 + 8'(i % 6));
			put2(LD_XL_IMMD, a);
			put2(op, b);
			put3(LD_DIR_XL, 16'h0010 + 16'(i));
			expect_store(16'h0010 + 16'(i), {8'h00, alu8_model(op, a, b)}, 2'b01);
		end
		run_program();

		begin_test("dir_load_add");
		for (int i = 0; i < 2; i++)
		begin
			w1 = 16'(next_rand() >> 8);
			w2 = 16'(next_rand() >> 8);
			dmem[8'h20 + 8'(2 * i)] = w1;
			dmem[8'h21 + 8'(2 * i)] = w2;
			put3(LD_XL_DIR, 16'h0020 + 16'(2 * i));
			put3(ADD_XL_DIR, 16'h0021 + 16'(2 * i));
			put3(LD_DIR_XL, 16'h0030 + 16'(i));
			expect_store(16'h0030 + 16'(i), {8'h00, w1[7:0] + w2[7:0]}, 2'b01);
		end
		run_program();

		begin_test("word_ops");
		w1 = 16'(next_rand() >> 8);
		w2 = 16'(next_rand() >> 8);
		put3(LDW_Y_IMMD, w1);
		put3(ADDW_Y_IMMD, w2);
		put1(LDW_X_Y);
		put3(LDW_DIR_Y, 16'h0040);
		put3(LD_DIR_XL, 16'h0042);
		w1 = w1 + w2;
		expect_store(16'h0040, w1, 2'b11);
		expect_store(16'h0042, {8'h00, w1[7:0]}, 2'b01);
		run_program();

		begin_test("branches");
		for (int i = 0; i < 8; i++)
		begin
			a = 8'(next_rand() >> 16);
			b = (i % 2 == 0) ? a : 8'(next_rand() >> 16);
			op = opcode_t'(8'h41 + 8'(i / 2));
			case (op)
				JRZ_D: taken = (a == b);
				JRNZ_D: taken = (a != b);
				JRC_D: taken = (a < b);
				default: taken = (a >= b);
			endcase
			put2(LD_XL_IMMD, a);
			put2(CP_XL_IMMD, b);
			// target lies past the fall-through store and its jr
			put2(op, 8'd5);
			put3(LD_DIR_XL, 16'h0050 + 16'(2 * i));
			put2(JR_D, 8'd3);
			put3(LD_DIR_XL, 16'h0051 + 16'(2 * i));
			expect_store(taken ? 16'h0051 + 16'(2 * i) : 16'h0050 + 16'(2 * i), {8'h00, a}, 2'b01);
		end
		run_program();

		$display("errors: store %0d, missing %0d, other %0d", store_errors, missing_errors,
			other_errors);
		if (store_errors + missing_errors + other_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/regfile.sv
rtl/fetch_unit.sv
rtl/exec_unit.sv
rtl/cpu_top.sv
verif/cpu_sva.sv
verif/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f list.f -o cpu_tb_sim \
	|| exit 1
./obj_dir/cpu_tb_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
